// File: axi_lite_addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_addr_decoder
    import axi_lite_xbar_pkg::*;
#(
    parameter bit WRITE_DECODE = 1'b0   // Set for the write direction
) (
    input  addr_t      i_addr,   // Address from master
    output slave_sel_t o_sel     // One-hot slave select
);

    slave_sel_t region_hit;   // Raw match against region table

    // Compare top byte with each table entry
    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            region_hit[s] = (i_addr[ADDR_WIDTH-1:REGION_LSB] == SLAVE_REGION[s]);
        end
    end

    // Read-only slaves drop out of the write decode
    assign o_sel = WRITE_DECODE ? (region_hit & SLAVE_WRITABLE) : region_hit;

    // Region table entries must be distinct
    always_comb begin
        assert ($onehot0(o_sel))
            else $error("decoder select not one-hot: %b", o_sel);
    end

endmodule

`default_nettype wire

// File: axi_lite_channel_router.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_channel_router
    import axi_lite_xbar_pkg::*;
#(
    parameter type payload_t = addr_req_t   // AW/AR or W payload
) (
    // Route
    input  slave_sel_t                i_sel,       // Target slave, one-hot or zero

    // Master side
    input  logic                      i_valid,
    output logic                      o_ready,
    input  payload_t                  i_payload,

    // Slave side
    output slave_sel_t                o_valid,
    input  slave_sel_t                i_ready,
    output payload_t [NUM_SLAVES-1:0] o_payload
);

    //////////////////////////////////////////////////
    // Forward path
    //////////////////////////////////////////////////
    // Valid only toward the selected slave
    assign o_valid = i_valid ? i_sel : '0;

    // Payload to the selected slave, zero elsewhere
    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            o_payload[s] = i_sel[s] ? i_payload : '0;
        end
    end

    //////////////////////////////////////////////////
    // Return path
    //////////////////////////////////////////////////
    // Ready of the selected slave only
    // No select means no ready, so unmapped requests stall
    // Qualified by valid so an idle master never sees ready
    assign o_ready = i_valid & (|(i_ready & i_sel));

endmodule

`default_nettype wire

// File: axi_lite_interconnect.f
axi_lite_xbar_pkg.sv
axi_lite_addr_decoder.sv
axi_lite_channel_router.sv
axi_lite_write_path.sv
axi_lite_read_path.sv
axi_lite_interconnect.sv
tb_axi_lite_interconnect.sv

// File: axi_lite_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_interconnect
    import axi_lite_xbar_pkg::*;
(
    input  logic           clk,
    input  logic           resetn,

    // Master write
    input  addr_req_t      i_m_aw,
    input  logic           i_m_awvalid,
    output logic           o_m_awready,
    input  wdata_req_t     i_m_w,
    input  logic           i_m_wvalid,
    output logic           o_m_wready,
    output logic           o_m_bvalid,
    input  logic           i_m_bready,

    // Master read
    input  addr_req_t      i_m_ar,
    input  logic           i_m_arvalid,
    output logic           o_m_arready,
    output logic           o_m_rvalid,
    input  logic           i_m_rready,
    output data_t          o_m_rdata,

    // Slave write, one lane per slave
    output addr_req_vec_t  o_s_aw,
    output slave_sel_t     o_s_awvalid,
    input  slave_sel_t     i_s_awready,
    output wdata_req_vec_t o_s_w,
    output slave_sel_t     o_s_wvalid,
    input  slave_sel_t     i_s_wready,
    input  slave_sel_t     i_s_bvalid,
    output slave_sel_t     o_s_bready,

    // Slave read
    output addr_req_vec_t  o_s_ar,
    output slave_sel_t     o_s_arvalid,
    input  slave_sel_t     i_s_arready,
    input  data_vec_t      i_s_rdata,
    input  slave_sel_t     i_s_rvalid,
    output slave_sel_t     o_s_rready
);

    // Write and read directions never interact
    axi_lite_write_path write_path (
        .clk        (clk),
        .resetn     (resetn),
        .i_m_aw     (i_m_aw),
        .i_m_awvalid(i_m_awvalid),
        .o_m_awready(o_m_awready),
        .i_m_w      (i_m_w),
        .i_m_wvalid (i_m_wvalid),
        .o_m_wready (o_m_wready),
        .o_m_bvalid (o_m_bvalid),
        .i_m_bready (i_m_bready),
        .o_s_aw     (o_s_aw),
        .o_s_awvalid(o_s_awvalid),
        .i_s_awready(i_s_awready),
        .o_s_w      (o_s_w),
        .o_s_wvalid (o_s_wvalid),
        .i_s_wready (i_s_wready),
        .i_s_bvalid (i_s_bvalid),
        .o_s_bready (o_s_bready)
    );

    axi_lite_read_path read_path (
        .clk        (clk),
        .resetn     (resetn),
        .i_m_ar     (i_m_ar),
        .i_m_arvalid(i_m_arvalid),
        .o_m_arready(o_m_arready),
        .o_m_rvalid (o_m_rvalid),
        .i_m_rready (i_m_rready),
        .o_m_rdata  (o_m_rdata),
        .o_s_ar     (o_s_ar),
        .o_s_arvalid(o_s_arvalid),
        .i_s_arready(i_s_arready),
        .i_s_rdata  (i_s_rdata),
        .i_s_rvalid (i_s_rvalid),
        .o_s_rready (o_s_rready)
    );

endmodule

`default_nettype wire

// File: axi_lite_interconnect_trace.txt
# op addr prot wdata strb slave slave_stall master_stall rdata
# op W write, R read, X write then address change, P write and read together
W 00000010 1 11223344 f 0 0 0 0
W 02000abc 2 a5a5a5a5 3 2 2 1 0
R 00000020 0 0 0 0 1 0 cafe0001
R 01000004 5 0 0 1 0 2 cafe0101
R 02001000 7 0 0 2 3 3 deadbeef
W 01000000 0 12345678 f N 0 0 0
W 7f000000 0 12345678 f N 0 0 0
R 05000000 0 0 0 N 0 0 0
X 00000100 3 0badf00d c 0 1 2 0
X 02000200 1 87654321 f 2 0 1 0
P 00000300 2 55aa55aa f 0 1 1 01234567
P 02000340 4 33cc33cc 5 2 0 2 89abcdef
W 0000fffc 6 ffffffff 8 0 4 0 0
R 00abcdef 3 0 0 0 2 2 5a5a0f0f

// File: axi_lite_read_path.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_read_path
    import axi_lite_xbar_pkg::*;
(
    input  logic          clk,
    input  logic          resetn,

    // Master side
    input  addr_req_t     i_m_ar,        // Read address and prot
    input  logic          i_m_arvalid,
    output logic          o_m_arready,
    output logic          o_m_rvalid,
    input  logic          i_m_rready,
    output data_t         o_m_rdata,

    // Slave side
    output addr_req_vec_t o_s_ar,
    output slave_sel_t    o_s_arvalid,
    input  slave_sel_t    i_s_arready,
    input  data_vec_t     i_s_rdata,
    input  slave_sel_t    i_s_rvalid,
    output slave_sel_t    o_s_rready
);

    slave_sel_t ar_dec_sel;   // Decoded read target
    slave_sel_t ar_sel;
    slave_sel_t rd_route;     // Slave held from AR to R
    logic       ar_busy;
    logic       ar_fire;
    logic       r_fire;

    axi_lite_addr_decoder #(
        .WRITE_DECODE(1'b0)
    ) ar_decoder (
        .i_addr(i_m_ar.addr),
        .o_sel (ar_dec_sel)
    );

    assign ar_sel = ar_busy ? '0 : ar_dec_sel;   // One read outstanding

    axi_lite_channel_router #(
        .payload_t(addr_req_t)
    ) ar_router (
        .i_sel    (ar_sel),
        .i_valid  (i_m_arvalid),
        .o_ready  (o_m_arready),
        .i_payload(i_m_ar),
        .o_valid  (o_s_arvalid),
        .i_ready  (i_s_arready),
        .o_payload(o_s_ar)
    );

    //////////////////////////////////////////////////
    // Read data return
    //////////////////////////////////////////////////
    assign o_m_rvalid = |(i_s_rvalid & rd_route);
    assign o_s_rready = i_m_rready ? rd_route : '0;

    // Data mux, zero when no read is open
    always_comb begin
        o_m_rdata = '0;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (rd_route[s]) begin
                o_m_rdata = i_s_rdata[s];
            end
        end
    end

    assign ar_fire = i_m_arvalid & o_m_arready;
    assign r_fire  = o_m_rvalid & i_m_rready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ar_busy  <= 1'b0;
            rd_route <= '0;
        end else if (ar_fire) begin
            ar_busy  <= 1'b1;
            rd_route <= ar_dec_sel;
        end else if (r_fire) begin
            ar_busy  <= 1'b0;
            rd_route <= '0;
        end
    end

    // Route fixed for the whole read
    assert property (@(posedge clk) disable iff (!resetn)
        (ar_busy && !r_fire) |=> $stable(rd_route));

endmodule

`default_nettype wire

// File: axi_lite_write_path.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_write_path
    import axi_lite_xbar_pkg::*;
(
    input  logic           clk,
    input  logic           resetn,

    // Master side
    input  addr_req_t      i_m_aw,        // Write address and prot
    input  logic           i_m_awvalid,
    output logic           o_m_awready,
    input  wdata_req_t     i_m_w,         // Write data and strobe
    input  logic           i_m_wvalid,
    output logic           o_m_wready,
    output logic           o_m_bvalid,
    input  logic           i_m_bready,

    // Slave side
    output addr_req_vec_t  o_s_aw,
    output slave_sel_t     o_s_awvalid,
    input  slave_sel_t     i_s_awready,
    output wdata_req_vec_t o_s_w,
    output slave_sel_t     o_s_wvalid,
    input  slave_sel_t     i_s_wready,
    input  slave_sel_t     i_s_bvalid,
    output slave_sel_t     o_s_bready
);

    slave_sel_t aw_dec_sel;   // Decoded write target
    slave_sel_t aw_sel;       // AW route, closed while busy
    slave_sel_t w_sel;        // W route
    slave_sel_t wr_route;     // Slave held from AW to B
    logic       aw_busy;      // One write outstanding
    logic       w_done;       // W beat already sent
    logic       aw_fire;
    logic       w_fire;
    logic       b_fire;

    axi_lite_addr_decoder #(
        .WRITE_DECODE(1'b1)
    ) aw_decoder (
        .i_addr(i_m_aw.addr),
        .o_sel (aw_dec_sel)
    );

    //////////////////////////////////////////////////
    // Request routing
    //////////////////////////////////////////////////
    assign aw_sel = aw_busy ? '0 : aw_dec_sel;   // Second AW waits for B

    // Before AW is taken, W follows a live AW only
    assign w_sel = w_done      ? '0 :
                   aw_busy     ? wr_route :
                   i_m_awvalid ? aw_dec_sel : '0;

    axi_lite_channel_router #(
        .payload_t(addr_req_t)
    ) aw_router (
        .i_sel    (aw_sel),
        .i_valid  (i_m_awvalid),
        .o_ready  (o_m_awready),
        .i_payload(i_m_aw),
        .o_valid  (o_s_awvalid),
        .i_ready  (i_s_awready),
        .o_payload(o_s_aw)
    );

    axi_lite_channel_router #(
        .payload_t(wdata_req_t)
    ) w_router (
        .i_sel    (w_sel),
        .i_valid  (i_m_wvalid),
        .o_ready  (o_m_wready),
        .i_payload(i_m_w),
        .o_valid  (o_s_wvalid),
        .i_ready  (i_s_wready),
        .o_payload(o_s_w)
    );

    //////////////////////////////////////////////////
    // Response routing and route state
    //////////////////////////////////////////////////
    assign o_m_bvalid = |(i_s_bvalid & wr_route);   // Held slave only
    assign o_s_bready = i_m_bready ? wr_route : '0;

    assign aw_fire = i_m_awvalid & o_m_awready;
    assign w_fire  = i_m_wvalid & o_m_wready;
    assign b_fire  = o_m_bvalid & i_m_bready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_busy  <= 1'b0;
            w_done   <= 1'b0;
            wr_route <= '0;
        end else begin
            if (aw_fire) begin
                aw_busy  <= 1'b1;
                wr_route <= aw_dec_sel;   // Latch target at address handshake
            end
            if (w_fire) begin
                w_done <= 1'b1;
            end
            if (b_fire) begin   // Write closed, path idle next cycle
                aw_busy  <= 1'b0;
                w_done   <= 1'b0;
                wr_route <= '0;
            end
        end
    end

    // Held route must survive address changes until B
    assert property (@(posedge clk) disable iff (!resetn)
        (aw_busy && !b_fire) |=> $stable(wr_route));

    // Route clear and busy flag must agree
    assert property (@(posedge clk) disable iff (!resetn)
        !aw_busy |-> !o_m_bvalid);

endmodule

`default_nettype wire

// File: axi_lite_xbar_pkg.sv
`default_nettype none

package axi_lite_xbar_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int NUM_SLAVES = 3;   // Slave ports on the crossbar
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = 4;   // One strobe per data byte
    localparam int PROT_WIDTH = 3;

    // Region byte is the top address byte
    localparam int REGION_LSB = 24;

    //////////////////////////////////////////////////
    // Region table
    //////////////////////////////////////////////////
    // Entry s is the region byte of slave s
    localparam logic [NUM_SLAVES-1:0][ADDR_WIDTH-REGION_LSB-1:0] SLAVE_REGION = {
        8'h02,   // Slave 2
        8'h01,   // Slave 1, read-only
        8'h00    // Slave 0
    };

    // Slaves that take writes
    localparam logic [NUM_SLAVES-1:0] SLAVE_WRITABLE = 3'b101;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////
    typedef logic [NUM_SLAVES-1:0] slave_sel_t;   // One-hot, zero means no slave

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [PROT_WIDTH-1:0] prot_t;

    // AW and AR payload
    typedef struct packed {
        addr_t addr;
        prot_t prot;
    } addr_req_t;

    // W payload
    typedef struct packed {
        data_t data;
        strb_t strb;
    } wdata_req_t;

    // Per-slave payload bundles, element s for slave s
    typedef addr_req_t  [NUM_SLAVES-1:0] addr_req_vec_t;
    typedef wdata_req_t [NUM_SLAVES-1:0] wdata_req_vec_t;
    typedef data_t      [NUM_SLAVES-1:0] data_vec_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_axi_lite_interconnect \
    -f axi_lite_interconnect.f -o sim_axi_lite_interconnect

./obj_dir/sim_axi_lite_interconnect > sim.log 2>&1 || true
cat sim.log

if grep -q "No errors" sim.log; then
    exit 0
else
    exit 1
fi

// File: tb_axi_lite_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_lite_interconnect
    import axi_lite_xbar_pkg::*;
;
    logic clk = 1'b0;
    logic resetn = 1'b0;
    addr_req_t m_aw, m_ar;
    wdata_req_t m_w;
    logic m_awvalid, m_wvalid, m_bready, m_arvalid, m_rready;
    logic o_m_awready, o_m_wready, o_m_bvalid, o_m_arready, o_m_rvalid;
    data_t o_m_rdata;
    addr_req_vec_t o_s_aw, o_s_ar;
    wdata_req_vec_t o_s_w;
    slave_sel_t o_s_awvalid, o_s_wvalid, o_s_bready, o_s_arvalid, o_s_rready;
    slave_sel_t s_awready, s_wready, s_bvalid, s_arready, s_rvalid;
    data_vec_t s_rdata;
    string q_op[$];
    addr_t q_addr[$];
    data_t q_prot[$], q_wdata[$], q_strb[$], q_rdata[$];
    int q_slv[$], q_sstall[$], q_mstall[$];
    int cycles = 0;
    int limit = 100000;

    always #4 clk = ~clk;   // 8 ns period

    axi_lite_interconnect i_dut (
        .clk(clk), .resetn(resetn),
        .i_m_aw(m_aw), .i_m_awvalid(m_awvalid), .o_m_awready(o_m_awready),
        .i_m_w(m_w), .i_m_wvalid(m_wvalid), .o_m_wready(o_m_wready),
        .o_m_bvalid(o_m_bvalid), .i_m_bready(m_bready),
        .i_m_ar(m_ar), .i_m_arvalid(m_arvalid), .o_m_arready(o_m_arready),
        .o_m_rvalid(o_m_rvalid), .i_m_rready(m_rready), .o_m_rdata(o_m_rdata),
        .o_s_aw(o_s_aw), .o_s_awvalid(o_s_awvalid), .i_s_awready(s_awready),
        .o_s_w(o_s_w), .o_s_wvalid(o_s_wvalid), .i_s_wready(s_wready),
        .i_s_bvalid(s_bvalid), .o_s_bready(o_s_bready),
        .o_s_ar(o_s_ar), .o_s_arvalid(o_s_arvalid), .i_s_arready(s_arready),
        .i_s_rdata(s_rdata), .i_s_rvalid(s_rvalid), .o_s_rready(o_s_rready)
    );

    // Run limit from trace length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the DUT did not finish the trace in %0d cycles", limit);
            $display("Errors found");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////
    // Compare tasks and helpers
    //////////////////////////////////////////////////
    task automatic check_sel(input string name, input slave_sel_t exp, input slave_sel_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    function automatic slave_sel_t sel_of(input int idx);
        slave_sel_t s;
        s = '0;
        if (idx >= 0) s[idx] = 1'b1;   // Negative index means no slave
        return s;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;   // Drive point after the edge
    endtask

    // Selected lane carries the request, other lanes zero
    task automatic check_lanes(input bit wr, input int slv, input addr_req_t a,
                               input wdata_req_t w);
        addr_req_t lane;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            lane = wr ? o_s_aw[s] : o_s_ar[s];
            check_data($sformatf("o_s_a%s[%0d].addr", wr ? "w" : "r", s),
                (s == slv) ? a.addr : '0, lane.addr);
            check_data($sformatf("o_s_a%s[%0d].prot", wr ? "w" : "r", s),
                (s == slv) ? data_t'(a.prot) : '0, data_t'(lane.prot));
            if (wr) begin
                check_data($sformatf("o_s_w[%0d].data", s),
                    (s == slv) ? w.data : '0, o_s_w[s].data);
                check_data($sformatf("o_s_w[%0d].strb", s),
                    (s == slv) ? data_t'(w.strb) : '0, data_t'(o_s_w[s].strb));
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Master and slave sequences
    //////////////////////////////////////////////////
    task automatic do_write(input int i, input bit change);
        slave_sel_t sel;
        sel = sel_of(q_slv[i]);
        m_aw = '{addr: q_addr[i], prot: prot_t'(q_prot[i])};
        m_w = '{data: q_wdata[i], strb: strb_t'(q_strb[i])};
        m_awvalid = 1'b1;
        m_wvalid = !change;   // With an address change W comes after AW
        s_awready = ~sel;     // Only the target's ready may count
        s_wready = ~sel;
        repeat (q_sstall[i]) begin   // Slave stall
            #1;
            check_sel("o_s_awvalid", sel, o_s_awvalid);
            check_sel("o_s_wvalid", change ? '0 : sel, o_s_wvalid);
            check_data("o_m_awready", '0, data_t'(o_m_awready));
            check_data("o_m_wready", '0, data_t'(o_m_wready));
            step();
        end
        s_awready = sel;
        s_wready = sel;
        #1;
        check_sel("o_s_awvalid", sel, o_s_awvalid);
        check_sel("o_s_wvalid", change ? '0 : sel, o_s_wvalid);
        check_data("o_m_awready", 32'd1, data_t'(o_m_awready));
        check_data("o_m_wready", data_t'(!change), data_t'(o_m_wready));
        check_lanes(1'b1, q_slv[i], m_aw, m_w);
        step();
        s_awready = change ? '1 : '0;   // Every slave ready, none may see AW
        m_awvalid = change;
        m_aw.addr = q_addr[i] ^ 32'h0200_0000;   // Swap region 0 and region 2
        if (change) begin
            // W after AW follows the held route
            m_wvalid = 1'b1;
            s_wready = '1;
            #1;
            check_sel("o_s_wvalid", sel, o_s_wvalid);
            check_data("o_m_wready", 32'd1, data_t'(o_m_wready));
            check_data($sformatf("o_s_w[%0d].data", q_slv[i]), m_w.data,
                o_s_w[q_slv[i]].data);
            check_sel("o_s_awvalid", '0, o_s_awvalid);
            check_data("o_m_awready", '0, data_t'(o_m_awready));
            step();
        end
        m_wvalid = change;   // Extra W beat must not pass
        s_wready = change ? '1 : '0;
        s_bvalid = sel;
        m_bready = 1'b0;
        repeat (q_mstall[i]) begin
            #1;
            check_data("o_m_bvalid", 32'd1, data_t'(o_m_bvalid));
            check_sel("o_s_bready", '0, o_s_bready);
            check_sel("o_s_awvalid", '0, o_s_awvalid);
            check_data("o_m_awready", '0, data_t'(o_m_awready));
            check_sel("o_s_wvalid", '0, o_s_wvalid);
            check_data("o_m_wready", '0, data_t'(o_m_wready));
            step();
        end
        m_bready = 1'b1;
        #1;
        check_data("o_m_bvalid", 32'd1, data_t'(o_m_bvalid));
        check_sel("o_s_bready", sel, o_s_bready);
        check_sel("o_s_awvalid", '0, o_s_awvalid);
        check_sel("o_s_wvalid", '0, o_s_wvalid);
        step();
        m_awvalid = 1'b0;
        m_wvalid = 1'b0;
        m_bready = 1'b0;
        s_bvalid = '1;   // Route closed, no slave may reach the master
        s_awready = '0;
        s_wready = '0;
        #1;
        check_data("o_m_bvalid", '0, data_t'(o_m_bvalid));
        step();
        s_bvalid = '0;
    endtask

    task automatic do_read(input addr_t addr, input int i, input int slv);
        slave_sel_t sel;
        sel = sel_of(slv);
        m_ar = '{addr: addr, prot: prot_t'(q_prot[i])};
        m_arvalid = 1'b1;
        s_arready = ~sel;   // Only the target's ready may count
        for (int s = 0; s < NUM_SLAVES; s++) s_rdata[s] = $urandom;   // Noise on all lanes
        repeat (q_sstall[i]) begin
            #1;
            check_sel("o_s_arvalid", sel, o_s_arvalid);
            check_data("o_m_arready", '0, data_t'(o_m_arready));
            step();
        end
        s_arready = sel;
        #1;
        check_sel("o_s_arvalid", sel, o_s_arvalid);
        check_data("o_m_arready", 32'd1, data_t'(o_m_arready));
        check_lanes(1'b0, slv, m_ar, '0);
        step();
        m_arvalid = 1'b0;
        s_arready = '0;
        s_rvalid = sel;
        m_rready = 1'b0;
        for (int s = 0; s < NUM_SLAVES; s++) s_rdata[s] = (s == slv) ? q_rdata[i] : $urandom;
        repeat (q_mstall[i]) begin
            #1;
            check_data("o_m_rvalid", 32'd1, data_t'(o_m_rvalid));
            check_sel("o_s_rready", '0, o_s_rready);
            step();
        end
        m_rready = 1'b1;
        #1;
        check_data("o_m_rvalid", 32'd1, data_t'(o_m_rvalid));
        check_data("o_m_rdata", q_rdata[i], o_m_rdata);
        check_sel("o_s_rready", sel, o_s_rready);
        step();
        m_rready = 1'b0;
        s_rvalid = '1;   // Route closed, no slave may reach the master
        #1;
        check_data("o_m_rvalid", '0, data_t'(o_m_rvalid));
        step();
        s_rvalid = '0;
    endtask

    // Unmapped or read-only target, no slave may react
    task automatic do_reject(input int i);
        bit wr;
        wr = (q_op[i] == "W");
        m_aw = '{addr: q_addr[i], prot: prot_t'(q_prot[i])};
        m_ar = m_aw;
        m_awvalid = wr;
        m_arvalid = !wr;
        s_awready = '1;
        s_arready = '1;
        repeat (10) begin
            #1;
            check_sel("o_s_awvalid", '0, o_s_awvalid);
            check_sel("o_s_arvalid", '0, o_s_arvalid);
            check_data("o_m_awready", '0, data_t'(o_m_awready));
            check_data("o_m_arready", '0, data_t'(o_m_arready));
            step();
        end
        m_awvalid = 1'b0;
        m_arvalid = 1'b0;
        s_awready = '0;
        s_arready = '0;
        // Nothing latched, so responses must not pass either way
        s_bvalid = '1;
        s_rvalid = '1;
        m_bready = 1'b1;
        m_rready = 1'b1;
        #1;
        check_data("o_m_bvalid", '0, data_t'(o_m_bvalid));
        check_data("o_m_rvalid", '0, data_t'(o_m_rvalid));
        check_sel("o_s_bready", '0, o_s_bready);
        check_sel("o_s_rready", '0, o_s_rready);
        step();
        s_bvalid = '0;
        s_rvalid = '0;
        m_bready = 1'b0;
        m_rready = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int fd;
        string line, op, slv;
        addr_t a;
        data_t p, wd, sb, rd;
        int ss, ms;
        void'($urandom(32'hcc49_c293));
        {m_aw, m_ar, m_w, m_awvalid, m_wvalid, m_bready, m_arvalid, m_rready} = '0;
        {s_awready, s_wready, s_bvalid, s_arready, s_rvalid, s_rdata} = '0;
        fd = $fopen("axi_lite_interconnect_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file");
            $display("Errors found");
            $fatal(1);
        end
        while ($fgets(line, fd)) begin
            if (line.len() < 2 || line[0] == "#") continue;
            void'($sscanf(line, "%s %h %h %h %h %s %d %d %h", op, a, p, wd, sb, slv, ss, ms, rd));
            q_op.push_back(op);
            q_addr.push_back(a);
            q_prot.push_back(p);
            q_wdata.push_back(wd);
            q_strb.push_back(sb);
            q_slv.push_back((slv == "N") ? -1 : slv.atoi());
            q_sstall.push_back(ss);
            q_mstall.push_back(ms);
            q_rdata.push_back(rd);
        end
        $fclose(fd);
        limit = 64 * q_op.size() + 20;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        // Slaves ready and responding, master valids low
        {s_awready, s_wready, s_arready, s_bvalid, s_rvalid} = '1;
        m_bready = 1'b1;
        m_rready = 1'b1;
        step();
        // Idle after reset
        check_sel("o_s_awvalid", '0, o_s_awvalid);
        check_sel("o_s_wvalid", '0, o_s_wvalid);
        check_sel("o_s_arvalid", '0, o_s_arvalid);
        check_sel("o_s_bready", '0, o_s_bready);
        check_sel("o_s_rready", '0, o_s_rready);
        check_data("o_m_awready", '0, data_t'(o_m_awready));
        check_data("o_m_wready", '0, data_t'(o_m_wready));
        check_data("o_m_arready", '0, data_t'(o_m_arready));
        check_data("o_m_bvalid", '0, data_t'(o_m_bvalid));
        check_data("o_m_rvalid", '0, data_t'(o_m_rvalid));
        {s_awready, s_wready, s_arready, s_bvalid, s_rvalid} = '0;
        m_bready = 1'b0;
        m_rready = 1'b0;
        foreach (q_op[i]) begin
            step();
            if (q_slv[i] < 0) do_reject(i);
            else if (q_op[i] == "W") do_write(i, 1'b0);
            else if (q_op[i] == "X") do_write(i, 1'b1);
            else if (q_op[i] == "R") do_read(q_addr[i], i, q_slv[i]);
            else if (q_op[i] == "P") begin
                fork   // Read side always aims at slave 1
                    do_write(i, 1'b0);
                    do_read({8'h01, q_addr[i][23:0]}, i, 1);
                join
            end else begin
                $display("Unknown operation in trace line %0d", i);
                $display("Errors found");
                $fatal(1);
            end
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
